// ==== Makefile ====
# Verilator build and run for the remote io host testbench

VERILATOR ?= verilator
TOP       ?= tb_rio_host
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^sim passed$$' $(LOG) || { echo "pass message missing from $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/rio_target_model.sv ====
// remote target model for the io link
// decodes command words from the line, keeps a register file and drives
// scrambled samples and replies early by a set lag
module rio_target_model #(
   parameter int n_channels  = 8,
   parameter int sample_bits = 24
) (
   input  logic                              clock,
   input  logic                              rst_n,
   input  logic                              sdio_out,
   input  logic                              sdio_oe,
   input  logic [2:0]                        lag,
   input  logic [n_channels*sample_bits-1:0] chan_data,
   output logic [8:0]                        frame_pos,
   output logic                              sdio_in
);
   localparam int n_bits = n_channels * sample_bits;

   logic              line_dly;    // sdio_out one clock late
   logic              oe_dly;
   logic [21:0]       cmd_sr;      // start bits, addr, data
   logic [15:0]       regs [16];
   logic [15:0]       reply;
   logic [n_bits-1:0] scr;         // msb goes out first
   logic [21:0]       prn;         // x^22+x^21+1, msb is the output
   logic [21:0]       prn_start;
   logic              is_cmd;
   int                s_off;
   int                r_off;
   logic              drive_bit;

   // scramble a whole frame, returns the advanced prn above the bits
   function automatic logic [n_bits+21:0] scramble_frame(
      input logic [n_bits-1:0] data,
      input logic [21:0]       p_in
   );
      logic [21:0]       p;
      logic [n_bits-1:0] s;
      p = p_in;
      for (int n = 0; n < n_bits; n++)
      begin
         s[n_bits-1-n] = data[n_bits-1-n] ^ p[21];
         p = {p[20:0], p[21] ^ p[20]};
      end
      return {p, s};
   endfunction

   assign is_cmd    = (cmd_sr[21:20] == 2'b00);      // idle word is all ones
   assign prn_start = (is_cmd && (cmd_sr[19:16] == 4'd4)) ? '1 : prn;

   always @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         frame_pos <= '0;
         line_dly  <= 1'b1;
         oe_dly    <= 1'b1;
         cmd_sr    <= '1;
         reply     <= '1;
         scr       <= '1;
         prn       <= '1;
         for (int i = 0; i < 16; i++)
            regs[i] <= '0;
      end
      else
      begin
         frame_pos <= frame_pos + 9'd1;              // mirrors the host counter
         line_dly  <= sdio_out;
         oe_dly    <= sdio_oe;
         if (frame_pos[0] && (frame_pos >= 9'd19) && (frame_pos <= 9'd61) && oe_dly)
            cmd_sr <= {cmd_sr[20:0], line_dly};      // one bit per 2 cycles
         if (frame_pos == 9'd63)
         begin
            {prn, scr} <= scramble_frame(chan_data, prn_start);
            reply      <= is_cmd ? regs[cmd_sr[19:16]] : '1;
            // no rd bit on the line, reply goes out before the write
            if (is_cmd)
               regs[cmd_sr[19:16]] <= cmd_sr[15:0];
         end
      end
   end

   assign s_off = int'(frame_pos) + int'(lag) - 76;   // 2 cycles per sample bit
   assign r_off = int'(frame_pos) + int'(lag) - 460;

   always_comb
   begin
      if ((s_off >= 0) && (s_off < 2 * n_bits))
         drive_bit = scr[n_bits - 1 - s_off / 2];
      else if ((r_off >= 0) && (r_off < 32))
         drive_bit = reply[15 - r_off / 2];          // reply is not scrambled
      else
         drive_bit = 1'b1;
   end

   initial
   begin
      sdio_in = 1'b1;
      forever
      begin
         @(posedge clock);
         #2;
         sdio_in = drive_bit;
      end
   end
endmodule

// ==== bench/tb_clock.sv ====
// testbench clock and reset
// free running clock, active low reset held for a few cycles
module tb_clock #(
   parameter int period       = 40,
   parameter int reset_cycles = 5
) (
   output logic clock,
   output logic rst_n
);
   initial
   begin
      clock = 1'b0;
      forever #(period / 2) clock = ~clock;
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clock);
      #2;
      rst_n = 1'b1;                  // release just after an edge
   end
endmodule

// ==== bench/tb_rio_host.sv ====
// testbench for the remote io host
// directed tests for the line command, write and read, and sample streaming
module tb_rio_host;
   import rio_pkg::*;

   localparam int n_channels  = 8;
   localparam int sample_bits = 24;
   localparam int frame_len   = 512;
   localparam int wait_limit  = 2 * frame_len;   // two frames
   localparam int tx_first    = 18;    // load at 16, first bit after the register
   localparam int tx_last     = 60;    // last driven position
   localparam int out_first   = 496;   // channel 0 slot
   localparam int reply_slot  = 504;

   logic                              clock;
   logic                              rst_n;
   logic                              wvalid;
   logic [1:0]                        addr;
   bus_word_t                         wdata;
   logic                              rvalid;
   bus_word_t                         rdata;
   logic                              sdio_in;
   logic                              sdio_out;
   logic                              sdio_oe;
   logic [2:0]                        lag;
   logic [n_channels*sample_bits-1:0] chan_data;
   logic [8:0]                        pos;          // frame position from the model
   logic [31:0]                       rng_state;
   sample_t                           exp_data [n_channels];

   tb_clock #(.period(40), .reset_cycles(5)) clock_inst (
      .clock (clock),
      .rst_n (rst_n)
   );

   rio_host #(.n_channels(n_channels), .sample_bits(sample_bits)) rio_host_inst (
      .clock    (clock),
      .rst_n    (rst_n),
      .wvalid   (wvalid),
      .addr     (addr),
      .wdata    (wdata),
      .rvalid   (rvalid),
      .rdata    (rdata),
      .sdio_in  (sdio_in),
      .sdio_out (sdio_out),
      .sdio_oe  (sdio_oe)
   );

   rio_target_model #(.n_channels(n_channels), .sample_bits(sample_bits)) target_inst (
      .clock     (clock),
      .rst_n     (rst_n),
      .sdio_out  (sdio_out),
      .sdio_oe   (sdio_oe),
      .lag       (lag),
      .chan_data (chan_data),
      .frame_pos (pos),
      .sdio_in   (sdio_in)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic bus_word_t cmd_word(input logic rd, input logic [3:0] target,
                                          input logic [15:0] payload);
      return {11'd0, rd, target, payload};
   endfunction

   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      assert (actual === expected) else
      begin
         $display("** Error: %s is %h, expected %h at frame pos %0d", name, actual,
                  expected, pos);
         abort_run();
      end
   endtask

   task automatic write_reg(input logic [1:0] a, input bus_word_t d);
      @(posedge clock);
      #2;
      wvalid = 1'b1;
      addr   = a;
      wdata  = d;
      @(posedge clock);
      #2;
      wvalid = 1'b0;                 // one clock write strobe
   endtask

   task automatic wait_pos(input int p);
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (pos != p)
      begin
         cycles++;
         assert (cycles < wait_limit) else
         begin
            $display("timeout waiting for frame position %0d", p);
            abort_run();
         end
         @(negedge clock);
      end
   endtask

   task automatic wait_rvalid();
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (!rvalid)
      begin
         cycles++;
         assert (cycles < wait_limit) else
         begin
            $display("timeout, no result word within two frames");
            abort_run();
         end
         @(negedge clock);
      end
   endtask

   // rvalid must stay low up to and including position p
   task automatic expect_quiet_until(input int p);
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge clock);
         check_value("rvalid", rvalid, 0);
         cycles++;
         assert (cycles < wait_limit) else
         begin
            $display("timeout waiting for frame position %0d", p);
            abort_run();
         end
      end
      while (pos != p);
   endtask

   task automatic fill_channels();
      for (int c = 0; c < n_channels; c++)
      begin
         rng_state   = lcg_next(rng_state);
         exp_data[c] = rng_state[31:8];
         chan_data[(n_channels-1-c)*sample_bits +: sample_bits] = rng_state[31:8];
      end
   endtask

   task automatic check_tx_frame(input logic [21:0] word);
      logic exp_bit;
      wait_pos(0);
      for (int p = 0; p <= tx_last + 1; p++)
      begin
         exp_bit = (p < tx_first) ? 1'b1 : word[21 - (p - tx_first) / 2];
         check_value("sdio_oe", sdio_oe, (p <= tx_last));
         if (p <= tx_last)
            check_value("sdio_out", sdio_out, exp_bit);
         @(negedge clock);
      end
   endtask

   task automatic test_reset_state();
      int cycles;
      cycles = 0;
      @(negedge clock);
      check_value("sdio_oe", sdio_oe, 1);   // still in reset
      check_value("sdio_out", sdio_out, 1);
      check_value("rvalid", rvalid, 0);
      while (!rst_n)
      begin
         cycles++;
         assert (cycles < wait_limit) else
         begin
            $display("reset was never released");
            abort_run();
         end
         @(negedge clock);
      end
      for (int i = 0; i < frame_len; i++)
      begin
         check_value("rvalid", rvalid, 0);
         check_value("sdio_out", sdio_out, 1);
         check_value("sdio_oe", sdio_oe, (pos <= tx_last));
         @(negedge clock);
      end
   endtask

   task automatic test_command_shift();
      wait_pos(100);                 // lands in the next frame
      write_reg(ADDR_CMD, cmd_word(1'b0, 4'h9, 16'h5A3C));
      check_tx_frame({2'b00, 4'h9, 16'h5A3C});
      check_tx_frame('1);            // nothing pending, idle word
   endtask

   task automatic test_write_read();
      wait_pos(0);
      write_reg(ADDR_CMD, cmd_word(1'b0, 4'd2, 16'hC35A));
      wait_pos(tx_first + 2);        // first command already loaded
      write_reg(ADDR_CMD, cmd_word(1'b1, 4'd2, 16'h0000));
      expect_quiet_until(frame_len - 1);
      wait_rvalid();
      check_value("reply pos", pos, reply_slot);
      check_value("rdata", rdata, 32'h0000C35A);
      expect_quiet_until(frame_len - 1);
   endtask

   task automatic test_stream(input logic [2:0] lag_v, input sample_delay_t delay_v);
      logic [7:0] mask;
      mask = 8'hA5;
      wait_pos(0);
      lag = lag_v;
      fill_channels();
      write_reg(ADDR_DELAY, {29'd0, delay_v});
      write_reg(ADDR_CMD, cmd_word(1'b0, 4'd4, 16'h0000));   // restarts both prns
      write_reg(ADDR_STREAM, {mask, 24'd2});
      for (int f = 0; f < 2; f++)
      begin
         for (int c = 0; c < n_channels; c++)
         begin
            if (mask[c])
            begin
               wait_rvalid();
               check_value("result pos", pos, out_first + c);
               check_value("rdata", rdata, {exp_data[c], 8'h00});
            end
         end
         expect_quiet_until(frame_len - 1);
         fill_channels();            // model takes it at pos 63
      end
      expect_quiet_until(frame_len - 1);   // count spent, silent frame
   endtask

   initial
   begin
      wvalid    = 1'b0;
      addr      = '0;
      wdata     = '0;
      lag       = 3'd3;              // matches the reset sample delay
      chan_data = '0;
      rng_state = 32'h939a3711;
      test_reset_state();
      test_command_shift();
      test_write_read();
      test_stream(3'd3, 3'd3);
      test_stream(3'd0, 3'd0);       // delay sweep
      test_stream(3'd6, 3'd6);
      $display("sim passed");
      $finish;
   end
endmodule

// ==== files.f ====
logic/rio_pkg.sv
logic/rio_reg_decode.sv
logic/rio_frame_engine.sv
logic/rio_line_sampler.sv
logic/rio_result_unit.sv
logic/rio_host.sv
bench/tb_clock.sv
bench/rio_target_model.sv
bench/tb_rio_host.sv

// ==== logic/rio_frame_engine.sv ====
// remote io frame engine
// frame counter, command shifter and line direction, plus the decode
// of frame positions into sample and reply capture strobes
module rio_frame_engine #(
   parameter int n_channels  = 8,
   parameter int sample_bits = 24
) (
   input  logic                clock,
   input  logic                rst_n,
   input  rio_pkg::cmd_t       pending_cmd,
   input  logic                cmd_pending,
   output rio_pkg::frame_pos_t frame_pos,
   output logic                tx_load,
   output logic                read_active,
   output logic                prn_reload,
   output rio_pkg::bit_evt_t   bit_evt,
   output logic                sdio_out,
   output logic                sdio_oe
);
   import rio_pkg::*;

   localparam int tx_bits    = $bits(cmd_t) + 1;   // 2 start bits, rd not sent
   localparam int sample_end = POS_SAMPLE_FIRST + 2 * n_channels * sample_bits;
   localparam int reply_end  = POS_REPLY_FIRST + 2 * $bits(reply_t);

   logic [tx_bits-1:0] tsr;          // transmit shifter, msb on the line
   frame_pos_t         next_pos;
   frame_pos_t         sample_off;   // distance from first sample bit
   frame_pos_t         reply_off;    // distance from first reply bit
   logic               in_samples;
   logic               in_reply;

   assign next_pos = frame_pos + 9'd1;   // wraps 511 -> 0
   assign tx_load  = (frame_pos == POS_TX_LOAD);

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         frame_pos   <= '0;
         tsr         <= '1;
         read_active <= 1'b0;
         prn_reload  <= 1'b0;
         sdio_out    <= 1'b1;          // idle line is high
         sdio_oe     <= 1'b1;
      end
      else
      begin
         frame_pos <= next_pos;
         if (tx_load)
         begin
            // start bits then addr and data, or all ones for an idle word
            tsr <= cmd_pending ? {2'b00, pending_cmd.target_addr, pending_cmd.payload} : '1;
            read_active <= cmd_pending && pending_cmd.rd;
            prn_reload  <= cmd_pending && (pending_cmd.target_addr == PRN_RESET_TARGET);
         end
         else if ((frame_pos > POS_TX_LOAD) && !frame_pos[0])
            tsr <= {tsr[tx_bits-2:0], 1'b1};   // one bit per 2 cycles
         sdio_out <= tsr[tx_bits-1];
         sdio_oe  <= (next_pos <= POS_TX_END);   // release line after command
      end
   end

   // capture strobes on even positions inside each section
   assign sample_off = frame_pos - POS_SAMPLE_FIRST;
   assign reply_off  = frame_pos - POS_REPLY_FIRST;
   assign in_samples = (frame_pos >= POS_SAMPLE_FIRST) && (frame_pos < sample_end)
                       && !frame_pos[0];
   assign in_reply   = (frame_pos >= POS_REPLY_FIRST) && (frame_pos < reply_end)
                       && !frame_pos[0];

   assign bit_evt.sample_strobe = in_samples;
   assign bit_evt.reply_strobe  = in_reply;
   assign bit_evt.index         = in_reply ? reply_off[8:1] : sample_off[8:1];

endmodule

// ==== logic/rio_host.sv ====
// remote io host
// runs the serial link to a remote target in 512 cycle frames and
// returns samples and read replies as 32 bit words
module rio_host #(
   parameter int n_channels  = 8,    // channels per frame
   parameter int sample_bits = 24    // bits per channel sample
) (
   input  logic               clock,
   input  logic               rst_n,
   input  logic               wvalid,
   input  logic [1:0]         addr,
   input  rio_pkg::bus_word_t wdata,
   output logic               rvalid,
   output rio_pkg::bus_word_t rdata,
   input  logic               sdio_in,
   output logic               sdio_out,
   output logic               sdio_oe
);
   import rio_pkg::*;

   cmd_t          pending_cmd;
   logic          cmd_pending;
   sample_delay_t sample_delay;
   stream_cfg_t   stream_cfg;
   logic          stream_step;
   frame_pos_t    frame_pos;
   logic          tx_load;
   logic          read_active;
   logic          prn_reload;
   bit_evt_t      bit_evt;
   rx_bit_t       rx_bit;

   rio_reg_decode reg_decode_inst (
      .clock        (clock),
      .rst_n        (rst_n),
      .wvalid       (wvalid),
      .addr         (addr),
      .wdata        (wdata),
      .tx_load      (tx_load),
      .pending_cmd  (pending_cmd),
      .cmd_pending  (cmd_pending),
      .sample_delay (sample_delay),
      .stream_cfg   (stream_cfg),
      .stream_step  (stream_step)
   );

   rio_frame_engine #(
      .n_channels  (n_channels),
      .sample_bits (sample_bits)
   ) frame_engine_inst (
      .clock       (clock),
      .rst_n       (rst_n),
      .pending_cmd (pending_cmd),
      .cmd_pending (cmd_pending),
      .frame_pos   (frame_pos),
      .tx_load     (tx_load),
      .read_active (read_active),
      .prn_reload  (prn_reload),
      .bit_evt     (bit_evt),
      .sdio_out    (sdio_out),
      .sdio_oe     (sdio_oe)
   );

   rio_line_sampler line_sampler_inst (
      .clock        (clock),
      .rst_n        (rst_n),
      .sdio_in      (sdio_in),
      .sample_delay (sample_delay),
      .bit_evt      (bit_evt),
      .prn_reload   (prn_reload),
      .frame_pos    (frame_pos),
      .rx_bit       (rx_bit)
   );

   rio_result_unit #(
      .n_channels  (n_channels),
      .sample_bits (sample_bits)
   ) result_unit_inst (
      .clock       (clock),
      .rst_n       (rst_n),
      .frame_pos   (frame_pos),
      .rx_bit      (rx_bit),
      .stream_cfg  (stream_cfg),
      .read_active (read_active),
      .stream_step (stream_step),
      .rvalid      (rvalid),
      .rdata       (rdata)
   );

endmodule

// ==== logic/rio_line_sampler.sv ====
// remote io line sampler
// delays sdio_in by the selected tap, descrambles sample bits with
// the x^22+x^21+1 prn and registers the captured bit
module rio_line_sampler (
   input  logic                   clock,
   input  logic                   rst_n,
   input  logic                   sdio_in,
   input  rio_pkg::sample_delay_t sample_delay,
   input  rio_pkg::bit_evt_t      bit_evt,
   input  logic                   prn_reload,
   input  rio_pkg::frame_pos_t    frame_pos,
   output rio_pkg::rx_bit_t       rx_bit
);
   import rio_pkg::*;

   localparam int dly_stages = 2 ** $bits(sample_delay_t);

   logic [dly_stages-1:0] dly_line;   // stage k holds sdio_in from k+1 clocks ago
   logic                  tap;
   prn_t                  prn;
   logic                  prn_fb;

   assign tap    = dly_line[sample_delay];   // round trip compensation
   assign prn_fb = prn[21] ^ prn[20];

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dly_line <= '1;
         prn      <= '1;
         rx_bit   <= '0;
      end
      else
      begin
         dly_line <= {dly_line[dly_stages-2:0], sdio_in};

         // target restarts its scrambler on the same command
         if (prn_reload && (frame_pos == POS_PRN_LOAD))
            prn <= '1;
         else if (bit_evt.sample_strobe)
            prn <= {prn[20:0], prn_fb};   // free runs across frames

         rx_bit.sample_strobe <= bit_evt.sample_strobe;
         rx_bit.reply_strobe  <= bit_evt.reply_strobe;
         rx_bit.value         <= tap ^ (bit_evt.sample_strobe & prn[21]);   // reply is clear
      end
   end

endmodule

// ==== logic/rio_pkg.sv ====
// remote io link package
// widths, frame positions, bus structs and FSM encodings shared by the host blocks
package rio_pkg;

   typedef logic [8:0]  frame_pos_t;      // cycle inside the 512 cycle frame
   typedef logic [31:0] bus_word_t;       // local bus data, result word
   typedef logic [23:0] sample_t;         // one channel sample
   typedef logic [15:0] reply_t;          // read reply from target
   typedef logic [21:0] prn_t;            // descrambler lfsr state
   typedef logic [2:0]  sample_delay_t;   // input delay tap

   // bus word bit 20 is rd, 19:16 target register, 15:0 data
   typedef struct packed {
      logic        rd;             // target answers with a reply
      logic [3:0]  target_addr;    // target register
      logic [15:0] payload;        // write data
   } cmd_t;

   typedef struct packed {
      logic [7:0]  mask;           // channel enables
      logic [23:0] frame_count;    // frames left to stream
   } stream_cfg_t;

   typedef struct packed {
      logic       sample_strobe;   // capture a sample bit now
      logic       reply_strobe;    // capture a reply bit now
      logic [7:0] index;           // bit number in its section
   } bit_evt_t;

   typedef struct packed {
      logic sample_strobe;         // value is a descrambled sample bit
      logic reply_strobe;          // value is a reply bit
      logic value;
   } rx_bit_t;

   localparam frame_pos_t POS_TX_LOAD       = 9'd16;    // shifter load
   localparam frame_pos_t POS_TX_END        = 9'd60;    // last driven cycle
   localparam frame_pos_t POS_PRN_LOAD      = 9'd77;    // optional prn restart
   localparam frame_pos_t POS_SAMPLE_FIRST  = 9'd78;    // first sample bit
   localparam frame_pos_t POS_REPLY_FIRST   = 9'd462;   // first reply bit
   localparam frame_pos_t POS_STREAM_DECIDE = 9'd495;   // enable latch
   localparam frame_pos_t POS_OUT_FIRST     = 9'd496;   // channel 0 word out

   localparam logic [1:0] ADDR_CMD    = 2'd0;
   localparam logic [1:0] ADDR_DELAY  = 2'd1;
   localparam logic [1:0] ADDR_STREAM = 2'd2;

   localparam logic [3:0] PRN_RESET_TARGET = 4'd4;   // target reg that restarts prn

   typedef enum logic [1:0] {
      out_idle,
      out_channels,
      out_reply
   } out_state_e;

endpackage

// ==== logic/rio_reg_decode.sv ====
// remote io bus register decode
// holds the pending command, input sample delay and stream configuration
module rio_reg_decode (
   input  logic                   clock,
   input  logic                   rst_n,
   input  logic                   wvalid,
   input  logic [1:0]             addr,
   input  rio_pkg::bus_word_t     wdata,
   input  logic                   tx_load,
   output rio_pkg::cmd_t          pending_cmd,
   output logic                   cmd_pending,
   output rio_pkg::sample_delay_t sample_delay,
   output rio_pkg::stream_cfg_t   stream_cfg,
   input  logic                   stream_step
);
   import rio_pkg::*;

   localparam sample_delay_t delay_rst = 3'd3;   // typical line round trip

   logic wr_cmd;
   logic wr_delay;
   logic wr_stream;

   assign wr_cmd    = wvalid && (addr == ADDR_CMD);
   assign wr_delay  = wvalid && (addr == ADDR_DELAY);
   assign wr_stream = wvalid && (addr == ADDR_STREAM);

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_pending  <= 1'b0;
         sample_delay <= delay_rst;
         stream_cfg   <= '0;          // mask off, nothing to stream
      end
      else
      begin
         if (wr_cmd)
            cmd_pending <= 1'b1;      // write at tx_load waits a frame
         else if (tx_load)
            cmd_pending <= 1'b0;      // taken by the shifter

         if (wr_delay)
            sample_delay <= wdata[2:0];

         if (wr_stream)
            stream_cfg <= wdata;      // mask in 31:24, count in 23:0
         else if (stream_step)
            stream_cfg.frame_count <= stream_cfg.frame_count - 24'd1;
      end
   end

   // command word itself, only meaningful while cmd_pending
   always_ff @(posedge clock)
   begin
      if (wr_cmd)
         pending_cmd <= wdata[$bits(cmd_t)-1:0];
   end

endmodule

// ==== logic/rio_result_unit.sv ====
// remote io result unit
// collects sample and reply bits, then issues enabled channel words
// and the read reply once per frame
module rio_result_unit #(
   parameter int n_channels  = 8,
   parameter int sample_bits = 24
) (
   input  logic                 clock,
   input  logic                 rst_n,
   input  rio_pkg::frame_pos_t  frame_pos,
   input  rio_pkg::rx_bit_t     rx_bit,
   input  rio_pkg::stream_cfg_t stream_cfg,
   input  logic                 read_active,
   output logic                 stream_step,
   output logic                 rvalid,
   output rio_pkg::bus_word_t   rdata
);
   import rio_pkg::*;

   localparam int store_bits = n_channels * sample_bits;
   localparam int chan_w     = $clog2(n_channels);
   localparam int out_last   = POS_OUT_FIRST + n_channels - 1;   // last channel slot

   logic [store_bits-1:0] store;       // channel 0 ends up in the top bits
   reply_t                reply_sr;
   out_state_e            state;
   logic [7:0]            enable;      // channels sent this frame
   frame_pos_t            out_off;
   logic [chan_w-1:0]     chan;
   sample_t               chan_word;

   // bits arrive msb first, channel 0 first
   always_ff @(posedge clock)
   begin
      if (rx_bit.sample_strobe)
         store <= {store[store_bits-2:0], rx_bit.value};
      if (rx_bit.reply_strobe)
         reply_sr <= {reply_sr[$bits(reply_t)-2:0], rx_bit.value};
   end

   assign stream_step = (frame_pos == POS_STREAM_DECIDE)
                        && (stream_cfg.frame_count != '0);   // one frame used up

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state  <= out_idle;
         enable <= '0;
      end
      else
      begin
         if (frame_pos == POS_STREAM_DECIDE)
            enable <= (stream_cfg.frame_count != '0) ? stream_cfg.mask : '0;

         case (state)
            out_idle:
            begin
               if (frame_pos == POS_STREAM_DECIDE)
                  state <= out_channels;
            end
            out_channels:
            begin
               if (frame_pos == out_last)
                  state <= out_reply;
            end
            out_reply:
               state <= out_idle;      // single reply slot
            default:
               state <= out_idle;
         endcase
      end
   end

   // channel slot follows the frame position
   assign out_off   = frame_pos - POS_OUT_FIRST;
   assign chan      = out_off[chan_w-1:0];
   assign chan_word = store[(n_channels - 1 - int'(chan)) * sample_bits +: sample_bits];

   always_comb
   begin
      rvalid = 1'b0;
      rdata  = '0;
      case (state)
         out_channels:
         begin
            rvalid = enable[chan];
            rdata  = {chan_word, 8'h00};   // sample left aligned
         end
         out_reply:
         begin
            rvalid = read_active;         // only if the command asked
            rdata  = {16'h0000, reply_sr};
         end
         default:
         begin
            rvalid = 1'b0;
            rdata  = '0;
         end
      endcase
   end

endmodule
